// File: hdl/muldiv_pkg.sv
/*
 * shared definitions for the multiply/divide execute unit
 *  - register data, register address and commit id widths
 *  - iteration count of the multiplier and the divider
 *  - M extension operation encoding
 *  - state encodings of both arithmetic units
 */
package muldiv_pkg;

    // datapath widths fixed by RV32
    localparam int REG_DATA_WIDTH  = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int COMMIT_ID_WIDTH = 3;

    // one iteration per operand bit, plus a sign fix step
    localparam int MULDIV_STEPS = 32;
    localparam int CNT_WIDTH    = 6;

    // bit 2 set means the divider class
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_e;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_RUN  = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

// File: hdl/muldiv_unit_if.sv
/*
 * start/busy/valid handshake between the controller
 * and one iterative arithmetic unit
 */
`timescale 1ns/1ps

interface muldiv_unit_if;
    import muldiv_pkg::*;

    // request side, sampled on the start edge
    logic                      start;
    muldiv_op_e                op;
    logic [REG_DATA_WIDTH-1:0] operand_a;
    logic [REG_DATA_WIDTH-1:0] operand_b;

    // response side
    logic                      busy;
    logic                      valid;
    logic [REG_DATA_WIDTH-1:0] result;

    modport ctrl (
        output start, op, operand_a, operand_b,
        input  busy, valid, result
    );

    modport unit (
        input  start, op, operand_a, operand_b,
        output busy, valid, result
    );

endinterface

// File: hdl/exu_muldiv_ctrl.sv
/*
 * multiply/divide controller
 *  - request acceptance and unit start
 *  - per class holding of rd, commit id and result
 *  - write-back arbitration, multiply first
 */
`timescale 1ns/1ps

module exu_muldiv_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   req_i,
    input  muldiv_pkg::muldiv_op_e                 op_i,
    input  logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  rs1_data_i,
    input  logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  rs2_data_i,
    input  logic [muldiv_pkg::REG_ADDR_WIDTH-1:0]  rd_addr_i,
    input  logic [muldiv_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    input  logic                                   hazard_stall_i,
    input  logic                                   int_assert_i,
    input  logic                                   wb_ready_i,
    muldiv_unit_if.ctrl                            mul_bus,
    muldiv_unit_if.ctrl                            div_bus,
    output logic                                   stall_o,
    output logic                                   reg_we_o,
    output logic [muldiv_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  reg_wdata_o,
    output logic [muldiv_pkg::COMMIT_ID_WIDTH-1:0] commit_id_o
);
    import muldiv_pkg::*;

    logic                       is_div;
    logic                       mul_blocked;
    logic                       div_blocked;
    logic                       accept;
    logic                       mul_start;
    logic                       div_start;
    logic                       sel_mul;
    logic                       sel_div;

    logic                       mul_held_q;
    logic                       div_held_q;
    logic                       div_owns_q;
    logic [REG_ADDR_WIDTH-1:0]  mul_rd_q;
    logic [REG_ADDR_WIDTH-1:0]  div_rd_q;
    logic [COMMIT_ID_WIDTH-1:0] mul_cid_q;
    logic [COMMIT_ID_WIDTH-1:0] div_cid_q;
    logic [REG_DATA_WIDTH-1:0]  mul_res_q;
    logic [REG_DATA_WIDTH-1:0]  div_res_q;

    always_comb begin
        is_div      = op_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        // a class is blocked while computing or while its result waits
        mul_blocked = mul_bus.busy | mul_held_q;
        div_blocked = div_bus.busy | div_held_q;
        stall_o     = req_i & (is_div ? div_blocked : mul_blocked);
        accept      = req_i & ~stall_o & ~hazard_stall_i & ~int_assert_i;
        mul_start   = accept & ~is_div;
        div_start   = accept & is_div;
    end

    // both units see the same operands, only start differs
    assign mul_bus.start     = mul_start;
    assign mul_bus.op        = op_i;
    assign mul_bus.operand_a = rs1_data_i;
    assign mul_bus.operand_b = rs2_data_i;
    assign div_bus.start     = div_start;
    assign div_bus.op        = op_i;
    assign div_bus.operand_a = rs1_data_i;
    assign div_bus.operand_b = rs2_data_i;

    // multiply wins, unless a divide result is already on the
    // write-back port and still waiting for wb_ready_i
    assign sel_mul = mul_held_q & ~div_owns_q;
    assign sel_div = div_held_q & ~sel_mul;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mul_held_q <= 1'b0;
            div_held_q <= 1'b0;
            div_owns_q <= 1'b0;
        end else begin
            if (mul_bus.valid) begin
                mul_held_q <= 1'b1;
            end else if (sel_mul && wb_ready_i) begin
                mul_held_q <= 1'b0;
            end
            if (div_bus.valid) begin
                div_held_q <= 1'b1;
            end else if (sel_div && wb_ready_i) begin
                div_held_q <= 1'b0;
            end
            div_owns_q <= sel_div & ~wb_ready_i;
        end
    end

    // write-back tags captured at start, results at valid
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_rd_q  <= rd_addr_i;
            mul_cid_q <= commit_id_i;
        end
        if (div_start) begin
            div_rd_q  <= rd_addr_i;
            div_cid_q <= commit_id_i;
        end
        if (mul_bus.valid) begin
            mul_res_q <= mul_bus.result;
        end
        if (div_bus.valid) begin
            div_res_q <= div_bus.result;
        end
    end

    always_comb begin
        reg_we_o = mul_held_q | div_held_q;
        if (sel_mul) begin
            reg_waddr_o = mul_rd_q;
            reg_wdata_o = mul_res_q;
            commit_id_o = mul_cid_q;
        end else if (sel_div) begin
            reg_waddr_o = div_rd_q;
            reg_wdata_o = div_res_q;
            commit_id_o = div_cid_q;
        end else begin
            reg_waddr_o = '0;
            reg_wdata_o = '0;
            commit_id_o = '0;
        end
    end

endmodule

// File: hdl/exu_mul.sv
/*
 * iterative 32 bit multiplier
 *  - MUL, MULH, MULHSU, MULHU
 *  - shift-add on operand magnitudes, sign fixed at the end
 */
`timescale 1ns/1ps

module exu_mul (
    input  logic        clk,
    input  logic        rst_n_i,
    muldiv_unit_if.unit bus
);
    import muldiv_pkg::*;

    mul_state_e                  state_q;
    logic [CNT_WIDTH-1:0]        cnt_q;
    muldiv_op_e                  op_q;
    logic                        neg_q;
    logic [REG_DATA_WIDTH-1:0]   mcand_q;
    logic [2*REG_DATA_WIDTH-1:0] prod_q;
    logic [REG_DATA_WIDTH-1:0]   result_q;

    logic                        a_neg;
    logic                        b_neg;
    logic [REG_DATA_WIDTH-1:0]   a_abs;
    logic [REG_DATA_WIDTH-1:0]   b_abs;
    logic [REG_DATA_WIDTH:0]     step_sum;
    logic [2*REG_DATA_WIDTH-1:0] prod_fixed;

    always_comb begin
        // rs1 is signed except for MULHU, rs2 only for MUL and MULH
        a_neg = (bus.op != OP_MULHU) & bus.operand_a[REG_DATA_WIDTH-1];
        b_neg = (bus.op inside {OP_MUL, OP_MULH}) & bus.operand_b[REG_DATA_WIDTH-1];
        a_abs = a_neg ? -bus.operand_a : bus.operand_a;
        b_abs = b_neg ? -bus.operand_b : bus.operand_b;
        // add multiplicand into the upper half when the low bit is set
        step_sum = {1'b0, prod_q[2*REG_DATA_WIDTH-1:REG_DATA_WIDTH]}
                 + (prod_q[0] ? {1'b0, mcand_q} : '0);
        prod_fixed = neg_q ? -prod_q : prod_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (bus.start) begin
                        state_q <= MUL_RUN;
                        cnt_q   <= '0;
                    end
                end
                MUL_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    // last count is the sign fix step
                    if (cnt_q == MULDIV_STEPS) begin
                        state_q <= MUL_DONE;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MUL_IDLE && bus.start) begin
            op_q    <= bus.op;
            neg_q   <= a_neg ^ b_neg;
            mcand_q <= a_abs;
            prod_q  <= {{REG_DATA_WIDTH{1'b0}}, b_abs};
        end else if (state_q == MUL_RUN) begin
            if (cnt_q < MULDIV_STEPS) begin
                prod_q <= {step_sum, prod_q[REG_DATA_WIDTH-1:1]};
            end else if (op_q == OP_MUL) begin
                result_q <= prod_fixed[REG_DATA_WIDTH-1:0];
            end else begin
                result_q <= prod_fixed[2*REG_DATA_WIDTH-1:REG_DATA_WIDTH];
            end
        end
    end

    // busy covers the valid cycle as well
    assign bus.busy   = (state_q != MUL_IDLE);
    assign bus.valid  = (state_q == MUL_DONE);
    assign bus.result = result_q;

endmodule

// File: hdl/exu_div.sv
/*
 * iterative restoring divider
 *  - DIV, DIVU, REM, REMU on operand magnitudes
 *  - divide by zero and signed overflow finish in one cycle
 */
`timescale 1ns/1ps

module exu_div (
    input  logic        clk,
    input  logic        rst_n_i,
    muldiv_unit_if.unit bus
);
    import muldiv_pkg::*;

    div_state_e                state_q;
    logic [CNT_WIDTH-1:0]      cnt_q;
    logic                      is_rem_q;
    logic                      q_neg_q;
    logic                      r_neg_q;
    logic [REG_DATA_WIDTH-1:0] dvsr_q;
    logic [REG_DATA_WIDTH-1:0] quo_q;
    logic [REG_DATA_WIDTH-1:0] rem_q;
    logic [REG_DATA_WIDTH-1:0] result_q;

    logic                      is_signed;
    logic                      is_rem;
    logic                      a_neg;
    logic                      b_neg;
    logic                      div_zero;
    logic                      overflow;
    logic [REG_DATA_WIDTH-1:0] a_abs;
    logic [REG_DATA_WIDTH-1:0] b_abs;
    logic [REG_DATA_WIDTH:0]   shifted;
    logic [REG_DATA_WIDTH+1:0] diff;
    logic [REG_DATA_WIDTH-1:0] quo_fixed;
    logic [REG_DATA_WIDTH-1:0] rem_fixed;

    always_comb begin
        is_signed = bus.op inside {OP_DIV, OP_REM};
        is_rem    = bus.op inside {OP_REM, OP_REMU};
        a_neg     = is_signed & bus.operand_a[REG_DATA_WIDTH-1];
        b_neg     = is_signed & bus.operand_b[REG_DATA_WIDTH-1];
        a_abs     = a_neg ? -bus.operand_a : bus.operand_a;
        b_abs     = b_neg ? -bus.operand_b : bus.operand_b;
        div_zero  = (bus.operand_b == '0);
        // most negative value divided by -1
        overflow  = is_signed && (bus.operand_a == {1'b1, {(REG_DATA_WIDTH-1){1'b0}}})
                    && (bus.operand_b == '1);
        // shift in the next dividend bit, try a subtract
        shifted   = {rem_q, quo_q[REG_DATA_WIDTH-1]};
        diff      = {1'b0, shifted} - {2'b00, dvsr_q};
        quo_fixed = q_neg_q ? -quo_q : quo_q;
        rem_fixed = r_neg_q ? -rem_q : rem_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (bus.start) begin
                        cnt_q   <= '0;
                        state_q <= (div_zero || overflow) ? DIV_DONE : DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == MULDIV_STEPS) begin
                        state_q <= DIV_DONE;
                    end
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == DIV_IDLE && bus.start) begin
            is_rem_q <= is_rem;
            q_neg_q  <= a_neg ^ b_neg;
            r_neg_q  <= a_neg;
            dvsr_q   <= b_abs;
            quo_q    <= a_abs;
            rem_q    <= '0;
            // spec corner cases bypass the iteration
            if (div_zero) begin
                result_q <= is_rem ? bus.operand_a : '1;
            end else if (overflow) begin
                result_q <= is_rem ? '0 : bus.operand_a;
            end
        end else if (state_q == DIV_RUN) begin
            if (cnt_q < MULDIV_STEPS) begin
                if (!diff[REG_DATA_WIDTH+1]) begin
                    rem_q <= diff[REG_DATA_WIDTH-1:0];
                    quo_q <= {quo_q[REG_DATA_WIDTH-2:0], 1'b1};
                end else begin
                    rem_q <= shifted[REG_DATA_WIDTH-1:0];
                    quo_q <= {quo_q[REG_DATA_WIDTH-2:0], 1'b0};
                end
            end else begin
                result_q <= is_rem_q ? rem_fixed : quo_fixed;
            end
        end
    end

    assign bus.busy   = (state_q != DIV_IDLE);
    assign bus.valid  = (state_q == DIV_DONE);
    assign bus.result = result_q;

endmodule

// File: hdl/exu_muldiv.sv
/*
 * multiply/divide execute unit top level
 *  - controller, iterative multiplier, iterative divider
 */
`timescale 1ns/1ps

module exu_muldiv (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   req_i,
    input  muldiv_pkg::muldiv_op_e                 op_i,
    input  logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  rs1_data_i,
    input  logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  rs2_data_i,
    input  logic [muldiv_pkg::REG_ADDR_WIDTH-1:0]  rd_addr_i,
    input  logic [muldiv_pkg::COMMIT_ID_WIDTH-1:0] commit_id_i,
    input  logic                                   hazard_stall_i,
    input  logic                                   int_assert_i,
    input  logic                                   wb_ready_i,
    output logic                                   stall_o,
    output logic                                   reg_we_o,
    output logic [muldiv_pkg::REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  reg_wdata_o,
    output logic [muldiv_pkg::COMMIT_ID_WIDTH-1:0] commit_id_o
);

    muldiv_unit_if mul_bus ();
    muldiv_unit_if div_bus ();

    exu_muldiv_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .op_i           (op_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .rd_addr_i      (rd_addr_i),
        .commit_id_i    (commit_id_i),
        .hazard_stall_i (hazard_stall_i),
        .int_assert_i   (int_assert_i),
        .wb_ready_i     (wb_ready_i),
        .mul_bus        (mul_bus.ctrl),
        .div_bus        (div_bus.ctrl),
        .stall_o        (stall_o),
        .reg_we_o       (reg_we_o),
        .reg_waddr_o    (reg_waddr_o),
        .reg_wdata_o    (reg_wdata_o),
        .commit_id_o    (commit_id_o)
    );

    exu_mul u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (mul_bus.unit)
    );

    exu_div u_div (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (div_bus.unit)
    );

endmodule

// File: test/exu_muldiv_chk.sv
/*
 * concurrent assertions on the multiply/divide controller
 *  - no unit start under interrupt, hazard or a busy unit
 *  - stable write-back while wb_ready_i is low
 *  - write-back idle right after reset
 */
`timescale 1ns/1ps

module exu_muldiv_chk (
    input logic                                   clk,
    input logic                                   rst_n_i,
    input logic                                   hazard_stall_i,
    input logic                                   int_assert_i,
    input logic                                   wb_ready_i,
    input logic                                   mul_start_i,
    input logic                                   div_start_i,
    input logic                                   mul_busy_i,
    input logic                                   div_busy_i,
    input logic                                   wb_we_i,
    input logic [muldiv_pkg::REG_ADDR_WIDTH-1:0]  wb_addr_i,
    input logic [muldiv_pkg::REG_DATA_WIDTH-1:0]  wb_data_i,
    input logic [muldiv_pkg::COMMIT_ID_WIDTH-1:0] wb_cid_i
);

    a_no_start_blocked: assert property (@(posedge clk) disable iff (!rst_n_i)
        (int_assert_i || hazard_stall_i) |-> !(mul_start_i || div_start_i))
        else $error("unit started while interrupt or hazard was asserted");

    a_no_start_mul_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        mul_start_i |-> !mul_busy_i)
        else $error("multiplier started while busy");

    a_no_start_div_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_start_i |-> !div_busy_i)
        else $error("divider started while busy");

    // held result must not move under back-pressure
    a_wb_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_we_i && !wb_ready_i) |=> (wb_we_i && $stable(wb_addr_i)
            && $stable(wb_data_i) && $stable(wb_cid_i)))
        else $error("write-back outputs changed while wb_ready_i was low");

    a_reset_idle: assert property (@(posedge clk) !rst_n_i |=> !wb_we_i)
        else $error("reg_we_o high right after reset");

endmodule

bind exu_muldiv_ctrl exu_muldiv_chk u_chk (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .hazard_stall_i (hazard_stall_i),
    .int_assert_i   (int_assert_i),
    .wb_ready_i     (wb_ready_i),
    .mul_start_i    (mul_start),
    .div_start_i    (div_start),
    .mul_busy_i     (mul_bus.busy),
    .div_busy_i     (div_bus.busy),
    .wb_we_i        (reg_we_o),
    .wb_addr_i      (reg_waddr_o),
    .wb_data_i      (reg_wdata_o),
    .wb_cid_i       (commit_id_o)
);

// File: test/tb_exu_muldiv.sv
/*
 * testbench for the multiply/divide execute unit
 *  - directed and random operation table against a reference model
 *  - mixed multiply/divide traffic, back-pressure, refused requests
 *  - write-back monitor and watchdog
 */
`timescale 1ns/1ps

module tb_exu_muldiv;
    import muldiv_pkg::*;

    localparam int WB_LIMIT      = 40;
    localparam int ROW_CYCLES    = 60;
    localparam int MARGIN_CYCLES = 600;
    localparam int RANDOM_ROWS   = 6;

    typedef struct {
        string                      name;
        muldiv_op_e                 op;
        logic [REG_DATA_WIDTH-1:0]  a;
        logic [REG_DATA_WIDTH-1:0]  b;
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [COMMIT_ID_WIDTH-1:0] cid;
    } row_t;

    typedef struct {
        logic [COMMIT_ID_WIDTH-1:0] cid;
        logic [REG_ADDR_WIDTH-1:0]  rd;
        logic [REG_DATA_WIDTH-1:0]  data;
    } wb_t;

    logic                       clk;
    logic                       rst_n_i;
    logic                       req_i;
    muldiv_op_e                 op_i;
    logic [REG_DATA_WIDTH-1:0]  rs1_data_i;
    logic [REG_DATA_WIDTH-1:0]  rs2_data_i;
    logic [REG_ADDR_WIDTH-1:0]  rd_addr_i;
    logic [COMMIT_ID_WIDTH-1:0] commit_id_i;
    logic                       hazard_stall_i;
    logic                       int_assert_i;
    logic                       wb_ready_i;
    logic                       stall_o;
    logic                       reg_we_o;
    logic [REG_ADDR_WIDTH-1:0]  reg_waddr_o;
    logic [REG_DATA_WIDTH-1:0]  reg_wdata_o;
    logic [COMMIT_ID_WIDTH-1:0] commit_id_o;

    row_t                       rows[$];
    wb_t                        wb_q[$];
    wb_t                        wb_entry;
    int                         errors;
    int                         seed;
    int                         waited;
    bit                         rows_ready = 1'b0;
    logic [2:0]                 rand_op;
    logic [REG_DATA_WIDTH-1:0]  rand_a;
    logic [REG_DATA_WIDTH-1:0]  rand_b;

    exu_muldiv u_exu_muldiv (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a transfer completes on the rising edge after this sample
    always @(negedge clk) begin
        if (rst_n_i && reg_we_o && wb_ready_i) begin
            wb_entry.cid  = commit_id_o;
            wb_entry.rd   = reg_waddr_o;
            wb_entry.data = reg_wdata_o;
            wb_q.push_back(wb_entry);
        end
    end

    initial begin
        wait (rows_ready);
        repeat (rows.size() * ROW_CYCLES + MARGIN_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

    // RV32 M results, spec values for divide by zero and overflow
    function automatic logic [31:0] ref_result(input muldiv_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] ub;
        logic signed [31:0] sa32;
        logic signed [31:0] sb32;
        logic [63:0]        prod;
        logic               ovf;
        begin
            sa   = {{32{a[31]}}, a};
            sb   = {{32{b[31]}}, b};
            ub   = {32'd0, b};
            sa32 = a;
            sb32 = b;
            ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
            case (op)
                OP_MUL, OP_MULH: prod = sa * sb;
                OP_MULHSU:       prod = sa * ub;
                default:         prod = {32'd0, a} * ub;
            endcase
            case (op)
                OP_MUL: return prod[31:0];
                OP_DIV: begin
                    if (b == 0) return 32'hffff_ffff;
                    if (ovf) return a;
                    return sa32 / sb32;
                end
                OP_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
                OP_REM: begin
                    if (b == 0) return a;
                    if (ovf) return 32'd0;
                    return sa32 % sb32;
                end
                OP_REMU: return (b == 0) ? a : a % b;
                default: return prod[63:32];
            endcase
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        begin
            if (expected !== actual) begin
                $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
                errors++;
            end
        end
    endtask

    task automatic add_row(input string name, input muldiv_op_e op, input logic [31:0] a,
                           input logic [31:0] b);
        row_t row;
        begin
            row.name = name;
            row.op   = op;
            row.a    = a;
            row.b    = b;
            row.rd   = (rows.size() % 31) + 1;
            row.cid  = rows.size() % 8;
            rows.push_back(row);
        end
    endtask

    task automatic drive_req(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] rd, input logic [2:0] cid);
        begin
            req_i       = 1'b1;
            op_i        = op;
            rs1_data_i  = a;
            rs2_data_i  = b;
            rd_addr_i   = rd;
            commit_id_i = cid;
        end
    endtask

    // holds the request until it is taken, ends 2 ns after the accepting edge
    task automatic issue_req(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b,
                             input logic [4:0] rd, input logic [2:0] cid);
        int stalled;
        begin
            drive_req(op, a, b, rd, cid);
            stalled = 0;
            @(negedge clk);
            while (stall_o && stalled < WB_LIMIT) begin
                @(negedge clk);
                stalled++;
            end
            if (stall_o) begin
                $display("request with commit id %0d was never accepted", cid);
                errors++;
            end
            @(posedge clk);
            #2;
            req_i = 1'b0;
        end
    endtask

    task automatic wait_result(input string name, input logic [2:0] cid, input logic [4:0] rd,
                               input logic [31:0] expected);
        int idx;
        int cycles;
        begin
            idx    = -1;
            cycles = 0;
            while (idx < 0 && cycles < WB_LIMIT) begin
                @(posedge clk);
                cycles++;
                foreach (wb_q[i]) begin
                    if (idx < 0 && wb_q[i].cid == cid) begin
                        idx = i;
                    end
                end
            end
            #2;
            if (idx < 0) begin
                $display("%s: no write-back with commit id %0d in %0d cycles", name, cid, cycles);
                errors++;
            end else begin
                check_value({name, " rd"}, rd, wb_q[idx].rd);
                check_value({name, " data"}, expected, wb_q[idx].data);
                wb_q.delete(idx);
            end
        end
    endtask

    task automatic wait_we(input string name);
        int cycles;
        begin
            cycles = 0;
            while (!reg_we_o && cycles < WB_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (!reg_we_o) begin
                $display("%s: reg_we_o never went high", name);
                errors++;
            end
            @(posedge clk);
            #2;
        end
    endtask

    // wb_ready_i low, the held result must not move
    task automatic hold_check(input string name, input int cycles, input bit want_stall);
        logic [31:0] data;
        logic [4:0]  addr;
        logic [2:0]  cid;
        begin
            data = reg_wdata_o;
            addr = reg_waddr_o;
            cid  = commit_id_o;
            repeat (cycles) begin
                @(negedge clk);
                check_value({name, " we"}, 1, reg_we_o);
                check_value({name, " data"}, data, reg_wdata_o);
                check_value({name, " addr"}, addr, reg_waddr_o);
                check_value({name, " commit id"}, cid, commit_id_o);
                if (want_stall) begin
                    check_value({name, " stall"}, 1, stall_o);
                end
            end
            @(posedge clk);
            #2;
        end
    endtask

    task automatic refused_req(input string name, input bit use_int, input muldiv_op_e op,
                               input logic [31:0] a, input logic [31:0] b,
                               input logic [4:0] rd, input logic [2:0] cid);
        begin
            int_assert_i   = use_int;
            hazard_stall_i = ~use_int;
            drive_req(op, a, b, rd, cid);
            repeat (WB_LIMIT) @(posedge clk);
            #2;
            if (wb_q.size() != 0) begin
                $display("%s: write-back seen although the request was blocked", name);
                errors++;
            end
            int_assert_i   = 1'b0;
            hazard_stall_i = 1'b0;
            issue_req(op, a, b, rd, cid);
            wait_result(name, cid, rd, ref_result(op, a, b));
        end
    endtask

    initial begin
        rst_n_i        = 1'b0;
        req_i          = 1'b0;
        op_i           = OP_MUL;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        rd_addr_i      = '0;
        commit_id_i    = '0;
        hazard_stall_i = 1'b0;
        int_assert_i   = 1'b0;
        wb_ready_i     = 1'b1;
        errors         = 0;
        seed           = 1134;

        add_row("mul_small", OP_MUL, 32'd7, 32'hffff_fffa);
        add_row("mul_wrap", OP_MUL, 32'h1234_5678, 32'h9abc_def0);
        add_row("mulh_min", OP_MULH, 32'h8000_0000, 32'h8000_0000);
        add_row("mulh_mixed", OP_MULH, 32'hffff_fffe, 32'h7fff_ffff);
        add_row("mulhsu_neg", OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
        add_row("mulhsu_pos", OP_MULHSU, 32'h7fff_ffff, 32'h8000_0000);
        add_row("mulhu_max", OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);
        add_row("div_neg", OP_DIV, 32'hffff_ff9c, 32'd7);
        add_row("div_mixed", OP_DIV, 32'd100, 32'hffff_fff9);
        add_row("divu_big", OP_DIVU, 32'hffff_ffff, 32'd3);
        add_row("rem_neg", OP_REM, 32'hffff_ff9c, 32'd7);
        add_row("remu_big", OP_REMU, 32'hffff_ffff, 32'd10);
        add_row("div_zero", OP_DIV, 32'd5, 32'd0);
        add_row("divu_zero", OP_DIVU, 32'h8000_0000, 32'd0);
        add_row("rem_zero", OP_REM, 32'hffff_fff0, 32'd0);
        add_row("remu_zero", OP_REMU, 32'd123, 32'd0);
        add_row("div_ovf", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
        add_row("rem_ovf", OP_REM, 32'h8000_0000, 32'hffff_ffff);
        add_row("divu_minus1", OP_DIVU, 32'h8000_0000, 32'hffff_ffff);
        add_row("remu_minus1", OP_REMU, 32'h8000_0000, 32'hffff_ffff);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            rand_op = $random(seed);
            rand_a  = $random(seed);
            rand_b  = $random(seed);
            add_row($sformatf("random_%0d", i), muldiv_op_e'(rand_op), rand_a, rand_b);
        end
        rows_ready = 1'b1;

        repeat (5) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        // request held off by hazard sees no stall from either class
        req_i          = 1'b1;
        hazard_stall_i = 1'b1;
        @(negedge clk);
        check_value("reset reg_we", 0, reg_we_o);
        check_value("reset mul stall", 0, stall_o);
        @(posedge clk);
        #2;
        op_i = OP_DIV;
        @(negedge clk);
        check_value("reset div stall", 0, stall_o);
        @(posedge clk);
        #2;
        req_i          = 1'b0;
        hazard_stall_i = 1'b0;

        foreach (rows[i]) begin
            issue_req(rows[i].op, rows[i].a, rows[i].b, rows[i].rd, rows[i].cid);
            wait_result(rows[i].name, rows[i].cid, rows[i].rd,
                        ref_result(rows[i].op, rows[i].a, rows[i].b));
        end

        // multiply and divide in flight together, both held before release
        wb_ready_i = 1'b0;
        issue_req(OP_MUL, 32'hffff_fff0, 32'h0000_0010, 5'd20, 3'd1);
        issue_req(OP_DIV, 32'h7fff_ffff, 32'hffff_fffd, 5'd21, 3'd2);
        wait_we("pair");
        hold_check("pair hold", WB_LIMIT, 1'b0);
        wb_ready_i = 1'b1;
        waited     = 0;
        while (wb_q.size() < 2 && waited < WB_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        #2;
        if (wb_q.size() < 2) begin
            $display("pair: both results were not written back");
            errors++;
        end else begin
            check_value("pair priority commit id", 1, wb_q[0].cid);
        end
        wait_result("pair mul", 3'd1, 5'd20, ref_result(OP_MUL, 32'hffff_fff0, 32'h10));
        wait_result("pair div", 3'd2, 5'd21, ref_result(OP_DIV, 32'h7fff_ffff, 32'hffff_fffd));

        // second multiply stalls behind a held multiply result
        wb_ready_i = 1'b0;
        issue_req(OP_MULH, 32'h0001_2345, 32'hfff0_0100, 5'd10, 3'd5);
        wait_we("backpressure");
        drive_req(OP_MULHU, 32'hffff_fff9, 32'd9, 5'd11, 3'd6);
        hold_check("backpressure hold", 10, 1'b1);
        wb_ready_i = 1'b1;
        issue_req(OP_MULHU, 32'hffff_fff9, 32'd9, 5'd11, 3'd6);
        wait_result("backpressure first", 3'd5, 5'd10,
                    ref_result(OP_MULH, 32'h0001_2345, 32'hfff0_0100));
        wait_result("backpressure second", 3'd6, 5'd11,
                    ref_result(OP_MULHU, 32'hffff_fff9, 32'd9));

        refused_req("int_blocked", 1'b1, OP_MULHU, 32'hdead_beef, 32'h0000_1000, 5'd25, 3'd7);
        refused_req("hazard_blocked", 1'b0, OP_REM, 32'hffff_f000, 32'd9, 5'd26, 3'd4);

        if (wb_q.size() != 0) begin
            $display("%0d unexpected extra write-backs seen", wb_q.size());
            errors++;
        end
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: exu_muldiv.f
hdl/muldiv_pkg.sv
hdl/muldiv_unit_if.sv
hdl/exu_muldiv_ctrl.sv
hdl/exu_mul.sv
hdl/exu_div.sv
hdl/exu_muldiv.sv
test/exu_muldiv_chk.sv
test/tb_exu_muldiv.sv
